/* src/tdc_pkg.sv */
// Shared constants of the TDC readout: widths, depths, APB offsets
// Sample word type and packed hit word

package tdc_pkg;

    localparam int NUM_CH     = 4;    // Channels in the array
    localparam int SAMPLE_W   = 16;   // Oversampled bits per CLK40 cycle
    localparam int TDC_W      = 12;   // Pulse width in bins, wraps at 4096
    localparam int EVT_W      = 16;   // Event counter, wraps
    localparam int CH_ID_W    = 4;
    localparam int LOST_W     = 8;    // Saturates at 255
    localparam int FIFO_DEPTH = 16;
    localparam int FILL_W     = 5;    // Holds 0 to FIFO_DEPTH

    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int CH_SEL_W   = $clog2(NUM_CH);
    localparam int ONES_W     = $clog2(SAMPLE_W + 1);  // Ones count of one word

    // APB register offsets
    localparam logic [7:0] ADDR_CTRL   = 8'h00;  // Soft clear
    localparam logic [7:0] ADDR_ENABLE = 8'h04;
    localparam logic [7:0] ADDR_FIFO   = 8'h08;  // Read pops
    localparam logic [7:0] ADDR_STATUS = 8'h0C;
    localparam logic [7:0] ADDR_LOST   = 8'h10;  // First of NUM_CH lost counters

    typedef logic [SAMPLE_W-1:0] sample_t;

    typedef struct packed {
        logic [CH_ID_W-1:0] ch_id;
        logic [EVT_W-1:0]   evt_cnt;
        logic [TDC_W-1:0]   tdc_val;
    } hit_t;

endpackage

/* src/tdc_csr.sv */
// APB register block: control, enable mask, FIFO data and status,
// per-channel lost counters

`timescale 1ns/10ps

module tdc_csr (
    input  logic                                           CLK40,
    input  logic                                           RST_SYNC,
    input  logic                                           psel,
    input  logic                                           penable,
    input  logic                                           pwrite,
    input  logic [7:0]                                     paddr,
    input  logic [31:0]                                    pwdata,
    output logic [31:0]                                    prdata,
    output logic                                           pready,
    output logic                                           pslverr,
    input  tdc_pkg::hit_t                                  fifo_head,
    input  logic                                           fifo_empty,
    input  logic [tdc_pkg::FILL_W-1:0]                     fifo_level,
    input  logic [tdc_pkg::NUM_CH-1:0][tdc_pkg::LOST_W-1:0] lost_cnt,
    output logic [tdc_pkg::NUM_CH-1:0]                     enable,
    output logic                                           soft_clr,
    output logic                                           pop
);
    import tdc_pkg::*;

    logic                access;
    logic                wr_acc;
    logic                rd_acc;
    logic [7:0]          lost_off;
    logic                lost_sel;
    logic [CH_SEL_W-1:0] lost_idx;

    assign access = psel && penable;  // Access phase, completes this cycle
    assign wr_acc = access && pwrite;
    assign rd_acc = access && !pwrite;
    assign pready = 1'b1;             // Zero wait states

    // Lost counters sit on word addresses from ADDR_LOST upward
    assign lost_off = paddr - ADDR_LOST;
    assign lost_sel = (paddr >= ADDR_LOST) && (lost_off < 8'(4 * NUM_CH)) &&
                      (paddr[1:0] == 2'b00);
    assign lost_idx = lost_off[CH_SEL_W+1:2];

    assign pop = rd_acc && (paddr == ADDR_FIFO) && !fifo_empty;

    always_ff @(posedge CLK40) begin
        if (RST_SYNC) begin
            enable <= '0;
        end else if (wr_acc && (paddr == ADDR_ENABLE)) begin
            enable <= pwdata[NUM_CH-1:0];
        end
    end

    always_ff @(posedge CLK40) begin
        if (RST_SYNC) begin
            soft_clr <= 1'b0;
        end else begin
            soft_clr <= wr_acc && (paddr == ADDR_CTRL) && pwdata[0];  // One-cycle pulse
        end
    end

    always_comb begin
        prdata  = '0;
        pslverr = 1'b0;
        if (access) begin
            if (lost_sel) begin
                pslverr = pwrite;  // Read only
                if (!pwrite) begin
                    prdata = 32'(lost_cnt[lost_idx]);
                end
            end else begin
                case (paddr)
                    ADDR_CTRL: begin
                        prdata = '0;  // Write only, reads as zero
                    end
                    ADDR_ENABLE: begin
                        if (!pwrite) begin
                            prdata = 32'(enable);
                        end
                    end
                    ADDR_FIFO: begin
                        if (pwrite || fifo_empty) begin
                            pslverr = 1'b1;  // Read only, and nothing to pop
                        end else begin
                            prdata = fifo_head;
                        end
                    end
                    ADDR_STATUS: begin
                        if (pwrite) begin
                            pslverr = 1'b1;
                        end else begin
                            prdata = 32'({fifo_level, 3'b000, fifo_empty});
                        end
                    end
                    default: begin
                        pslverr = 1'b1;  // Unmapped
                    end
                endcase
            end
        end
    end

endmodule

/* src/tdc_channel.sv */
// One TDC channel: WAIT/COUNT pulse FSM, width accumulator, event counter,
// one-entry output register and saturating lost counter

`timescale 1ns/10ps

module tdc_channel #(
    parameter int CH_ID = 0  // Must fit in CH_ID_W bits
) (
    input  logic                        CLK40,
    input  logic                        RST_SYNC,
    input  logic                        soft_clr,
    input  logic                        enable,
    input  tdc_pkg::sample_t            sample,
    input  logic                        ack,
    output logic                        pending,
    output tdc_pkg::hit_t               hit,
    output logic [tdc_pkg::LOST_W-1:0]  lost_cnt
);
    import tdc_pkg::*;

    typedef enum logic {WAIT, COUNT} state_t;

    state_t            state;
    sample_t           sample_q;
    logic [ONES_W-1:0] ones;
    logic [TDC_W-1:0]  acc;
    logic [TDC_W-1:0]  tdc_val;
    logic [EVT_W-1:0]  evt_cnt;
    logic              start;
    logic              finish;
    logic              load;
    logic              lost;

    always_ff @(posedge CLK40) begin
        sample_q <= sample;  // Input stage, word seen one cycle later
    end

    // Population count of the sample word
    always_comb begin
        ones = '0;
        for (int i = 0; i < SAMPLE_W; i++) begin
            ones = ones + ONES_W'(sample_q[i]);
        end
    end

    assign start   = (state == WAIT) && enable && (|sample_q);
    assign finish  = (state == COUNT) && !(&sample_q);  // Any zero ends the pulse
    assign tdc_val = acc + TDC_W'(ones);
    assign load    = finish && (!pending || ack);      // Register free this edge
    assign lost    = finish && pending && !ack;

    always_ff @(posedge CLK40) begin
        if (RST_SYNC || soft_clr) begin
            state <= WAIT;
        end else if (start) begin
            state <= COUNT;
        end else if (finish) begin
            state <= WAIT;
        end
    end

    always_ff @(posedge CLK40) begin
        if (start) begin
            acc <= TDC_W'(ones);
        end else if (state == COUNT) begin
            acc <= tdc_val;
        end
    end

    always_ff @(posedge CLK40) begin
        if (RST_SYNC || soft_clr) begin
            evt_cnt <= '0;
        end else if (finish) begin
            evt_cnt <= evt_cnt + 1'b1;  // Advances on lost hits too
        end
    end

    always_ff @(posedge CLK40) begin
        if (RST_SYNC || soft_clr) begin
            pending <= 1'b0;
        end else if (load) begin
            pending <= 1'b1;
        end else if (ack) begin
            pending <= 1'b0;
        end
    end

    always_ff @(posedge CLK40) begin
        if (load) begin
            hit <= '{ch_id: CH_ID_W'(CH_ID), evt_cnt: evt_cnt, tdc_val: tdc_val};
        end
    end

    always_ff @(posedge CLK40) begin
        if (RST_SYNC || soft_clr) begin
            lost_cnt <= '0;
        end else if (lost && (lost_cnt != '1)) begin
            lost_cnt <= lost_cnt + 1'b1;  // Saturating
        end
    end

endmodule

/* src/hit_merger.sv */
// Round-robin merger from channel output registers into the hit FIFO

`timescale 1ns/10ps

module hit_merger (
    input  logic                                CLK40,
    input  logic                                RST_SYNC,
    input  logic                                soft_clr,
    input  logic [tdc_pkg::NUM_CH-1:0]          pending,
    input  tdc_pkg::hit_t [tdc_pkg::NUM_CH-1:0] hits,
    output logic [tdc_pkg::NUM_CH-1:0]          ack,
    input  logic                                fifo_full,
    output logic                                push,
    output tdc_pkg::hit_t                       push_data
);
    import tdc_pkg::*;

    logic [CH_SEL_W-1:0] last_grant;
    logic [CH_SEL_W-1:0] sel;
    logic                found;

    // Search starts one past the last channel granted
    always_comb begin
        logic [CH_SEL_W-1:0] idx;
        sel   = last_grant;
        found = 1'b0;
        for (int i = 1; i <= NUM_CH; i++) begin
            idx = CH_SEL_W'((int'(last_grant) + i) % NUM_CH);
            if (!found && pending[idx]) begin
                sel   = idx;
                found = 1'b1;
            end
        end
    end

    assign push      = found && !fifo_full;  // Full FIFO stalls every channel
    assign ack       = push ? (NUM_CH'(1) << sel) : '0;
    assign push_data = hits[sel];

    always_ff @(posedge CLK40) begin
        if (RST_SYNC || soft_clr) begin
            last_grant <= CH_SEL_W'(NUM_CH - 1);  // Channel 0 goes first
        end else if (push) begin
            last_grant <= sel;
        end
    end

endmodule

/* src/hit_fifo.sv */
// Synchronous hit word FIFO with fill level and read-through head

`timescale 1ns/10ps

module hit_fifo (
    input  logic                       CLK40,
    input  logic                       RST_SYNC,
    input  logic                       soft_clr,
    input  logic                       push,
    input  tdc_pkg::hit_t              push_data,
    input  logic                       pop,
    output tdc_pkg::hit_t              head,
    output logic                       empty,
    output logic                       full,
    output logic [tdc_pkg::FILL_W-1:0] level
);
    import tdc_pkg::*;

    hit_t               mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic               wr_en;
    logic               rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;

    always_ff @(posedge CLK40) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge CLK40) begin
        if (RST_SYNC || soft_clr) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps with power-of-two depth
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: level <= level;
            endcase
        end
    end

    assign head  = mem[rd_ptr];
    assign empty = (level == '0);
    assign full  = (level == FILL_W'(FIFO_DEPTH));

endmodule

/* src/tdc_array_top.sv */
// Four-channel TDC array: register block, channel cores, merger and hit FIFO

`timescale 1ns/10ps

module tdc_array_top (
    input  logic                                  CLK40,
    input  logic                                  RST_SYNC,
    input  tdc_pkg::sample_t [tdc_pkg::NUM_CH-1:0] samples,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [7:0]                            paddr,
    input  logic [31:0]                           pwdata,
    output logic [31:0]                           prdata,
    output logic                                  pready,
    output logic                                  pslverr
);
    import tdc_pkg::*;

    logic [NUM_CH-1:0]             enable;
    logic                          soft_clr;
    logic                          pop;
    logic [NUM_CH-1:0]             pending;
    logic [NUM_CH-1:0]             ack;
    hit_t [NUM_CH-1:0]             hits;
    logic [NUM_CH-1:0][LOST_W-1:0] lost_cnt;
    logic                          push;
    hit_t                          push_data;
    hit_t                          fifo_head;
    logic                          fifo_empty;
    logic                          fifo_full;
    logic [FILL_W-1:0]             fifo_level;

    tdc_csr u_csr (
        .CLK40      (CLK40),
        .RST_SYNC   (RST_SYNC),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .fifo_head  (fifo_head),
        .fifo_empty (fifo_empty),
        .fifo_level (fifo_level),
        .lost_cnt   (lost_cnt),
        .enable     (enable),
        .soft_clr   (soft_clr),
        .pop        (pop)
    );

    for (genvar ch = 0; ch < NUM_CH; ch++) begin : g_ch
        tdc_channel #(.CH_ID(ch)) u_channel (
            .CLK40    (CLK40),
            .RST_SYNC (RST_SYNC),
            .soft_clr (soft_clr),
            .enable   (enable[ch]),
            .sample   (samples[ch]),
            .ack      (ack[ch]),
            .pending  (pending[ch]),
            .hit      (hits[ch]),
            .lost_cnt (lost_cnt[ch])
        );
    end

    hit_merger u_merger (
        .CLK40     (CLK40),
        .RST_SYNC  (RST_SYNC),
        .soft_clr  (soft_clr),
        .pending   (pending),
        .hits      (hits),
        .ack       (ack),
        .fifo_full (fifo_full),
        .push      (push),
        .push_data (push_data)
    );

    hit_fifo u_fifo (
        .CLK40     (CLK40),
        .RST_SYNC  (RST_SYNC),
        .soft_clr  (soft_clr),
        .push      (push),
        .push_data (push_data),
        .pop       (pop),
        .head      (fifo_head),
        .empty     (fifo_empty),
        .full      (fifo_full),
        .level     (fifo_level)
    );

endmodule

/* verif/tdc_array_tb.sv */
// TDC array testbench with clock, reset, LCG pulse stream and APB tasks
// Channel reference model, hit checks and cycle limit

`timescale 1ns/10ps

module tdc_array_tb;
    import tdc_pkg::*;

    localparam int MAX_CYCLES  = 20000;
    localparam int MODEL_DEPTH = 512;  // Events per channel between clears

    logic                     CLK40;
    logic                     RST_SYNC;
    sample_t [NUM_CH-1:0]     samples;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [7:0]               paddr;
    logic [31:0]              pwdata;
    logic [31:0]              prdata;
    logic                     pready;
    logic                     pslverr;

    logic [31:0]       rng_state = 32'hbe8;
    int                gen_cycles = 0;   // Words of pulse stream still to send
    int                gap_words = 40;   // Upper bound of the gap between pulses
    int                gap_left [NUM_CH];
    int                high_left [NUM_CH];
    int                cycle_count = 0;
    logic [NUM_CH-1:0] en_mask = '0;

    // Reference model state per channel
    logic              m_busy [NUM_CH];
    logic [TDC_W-1:0]  m_acc [NUM_CH];
    int                m_cnt [NUM_CH];
    logic [TDC_W-1:0]  exp_val [NUM_CH][MODEL_DEPTH];
    int                rd_next [NUM_CH];
    int                skipped [NUM_CH];

    tdc_array_top uut (
        .CLK40    (CLK40),
        .RST_SYNC (RST_SYNC),
        .samples  (samples),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

    initial begin
        CLK40 = 1'b0;
        forever #2 CLK40 = ~CLK40;
    end

    task automatic stop_with_failure();
        $display("Result: FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic expect_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int random_below(input int n);
        return int'(next_random() >> 8) % n;
    endfunction

    // Next bin of a channel's stream of random gaps and pulses of 1 to 60 bins
    function automatic logic next_bit(input int ch);
        if (high_left[ch] == 0 && gap_left[ch] == 0) begin
            gap_left[ch]  = 1 + 16 * random_below(gap_words) + random_below(16);
            high_left[ch] = 1 + random_below(60);
        end
        if (gap_left[ch] > 0) begin
            gap_left[ch] = gap_left[ch] - 1;
            return 1'b0;
        end
        high_left[ch] = high_left[ch] - 1;
        return 1'b1;
    endfunction

    // Channel rule applied to each word in the order it is sent
    task automatic apply_rule(input int ch, input sample_t word);
        logic [TDC_W-1:0] ones;
        ones = TDC_W'($countones(word));
        if (!m_busy[ch]) begin
            if (en_mask[ch] && (word != '0)) begin
                m_busy[ch] = 1'b1;
                m_acc[ch]  = ones;
            end
        end else if (word != '1) begin
            assert (m_cnt[ch] < MODEL_DEPTH) else begin
                $display("model event table overflowed on channel %0d", ch);
                stop_with_failure();
            end
            m_busy[ch]            = 1'b0;
            exp_val[ch][m_cnt[ch]] = m_acc[ch] + ones;  // Finishing word counts too
            m_cnt[ch]             = m_cnt[ch] + 1;
        end else begin
            m_acc[ch] = m_acc[ch] + ones;
        end
    endtask

    task automatic clear_model();
        for (int ch = 0; ch < NUM_CH; ch++) begin
            m_busy[ch]  = 1'b0;
            m_cnt[ch]   = 0;
            rd_next[ch] = 0;
            skipped[ch] = 0;
        end
    endtask

    always @(negedge CLK40) begin
        sample_t word;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            word = '0;
            if (gen_cycles > 0) begin
                for (int b = SAMPLE_W - 1; b >= 0; b--) begin
                    word[b] = next_bit(ch);  // MSB is the earliest bin
                end
            end
            samples[ch] = word;
            apply_rule(ch, word);
        end
        if (gen_cycles > 0) begin
            gen_cycles = gen_cycles - 1;
        end
    end

    always @(posedge CLK40) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            stop_with_failure();
        end
    end

    task automatic bus_transfer(input logic wr, input logic [7:0] addr,
                                input logic [31:0] wdata,
                                output logic [31:0] rdata, output logic err);
        @(negedge CLK40);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge CLK40);
        penable = 1'b1;
        #1;  // Access phase settled before the completing edge
        rdata = prdata;
        err   = pslverr;
        expect_value("pready", 32'(pready), 32'd1);
        @(negedge CLK40);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] rdata,
                            output logic err);
        bus_transfer(1'b0, addr, 32'h0, rdata, err);
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] wdata,
                             output logic err);
        logic [31:0] unused;
        bus_transfer(1'b1, addr, wdata, unused, err);
    endtask

    task automatic set_enable(input logic [NUM_CH-1:0] mask);
        logic [31:0] rdata;
        logic        err;
        write_reg(ADDR_ENABLE, 32'(mask), err);
        expect_value("pslverr", 32'(err), 32'd0);
        en_mask = mask;
        read_reg(ADDR_ENABLE, rdata, err);
        expect_value("enable", rdata, 32'(mask));
    endtask

    // Read word checked by channel and event number against the model
    task automatic match_hit(input hit_t h, input bit allow_skip);
        int ch;
        int evt;
        ch  = int'(h.ch_id);
        evt = int'(h.evt_cnt);
        assert (ch < NUM_CH && en_mask[ch]) else begin
            $display("read a hit from channel %0d, which is disabled or absent", ch);
            stop_with_failure();
        end
        if (allow_skip) begin
            assert (evt >= rd_next[ch]) else begin
                $display("event number went backwards on channel %0d", ch);
                stop_with_failure();
            end
            skipped[ch] = skipped[ch] + evt - rd_next[ch];
        end else begin
            expect_value($sformatf("evt_cnt ch%0d", ch), 32'(evt), 32'(rd_next[ch]));
        end
        assert (evt < m_cnt[ch]) else begin
            $display("read event %0d on channel %0d that the model never saw", evt, ch);
            stop_with_failure();
        end
        expect_value($sformatf("tdc_val ch%0d evt%0d", ch, evt), 32'(h.tdc_val),
                     32'(exp_val[ch][evt]));
        rd_next[ch] = evt + 1;
    endtask

    task automatic drain_fifo(input bit allow_skip);
        logic [31:0] rdata;
        logic        err;
        bit          done;
        done = 1'b0;
        repeat (8) @(negedge CLK40);  // Last pulses reach the output registers
        while (!done) begin
            read_reg(ADDR_FIFO, rdata, err);
            if (!err) begin
                match_hit(hit_t'(rdata), allow_skip);
            end else begin
                repeat (8) @(negedge CLK40);  // Merger moves any pending hit
                read_reg(ADDR_STATUS, rdata, err);
                done = rdata[0];
            end
        end
    endtask

    task automatic poll_stream(input int cycles, input bit allow_skip);
        logic [31:0] rdata;
        logic        err;
        @(posedge CLK40);
        gen_cycles = cycles;
        while (gen_cycles > 0) begin
            read_reg(ADDR_FIFO, rdata, err);
            if (!err) begin
                match_hit(hit_t'(rdata), allow_skip);
            end
        end
        drain_fifo(allow_skip);
    endtask

    task automatic expect_lossless();
        logic [31:0] rdata;
        logic        err;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            expect_value($sformatf("events read ch%0d", ch), 32'(rd_next[ch]),
                         32'(m_cnt[ch]));
            read_reg(ADDR_LOST + 8'(4 * ch), rdata, err);
            expect_value($sformatf("lost_cnt ch%0d", ch), rdata, 32'h0);
        end
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        int          burst_base [NUM_CH];
        RST_SYNC = 1'b1;
        samples  = '0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            gap_left[ch]  = 0;
            high_left[ch] = 0;
        end
        clear_model();
        repeat (10) @(negedge CLK40);
        RST_SYNC = 1'b0;

        read_reg(ADDR_STATUS, rdata, err);
        expect_value("status", rdata, 32'h1);  // Empty with level 0
        read_reg(ADDR_ENABLE, rdata, err);
        expect_value("enable", rdata, 32'h0);
        expect_lossless();

        read_reg(ADDR_FIFO, rdata, err);
        expect_value("pslverr", 32'(err), 32'd1);
        expect_value("prdata", rdata, 32'h0);
        read_reg(8'h20, rdata, err);
        expect_value("pslverr", 32'(err), 32'd1);
        write_reg(ADDR_STATUS, 32'h0, err);
        expect_value("pslverr", 32'(err), 32'd1);

        set_enable(4'b0101);  // Channels 1 and 3 must stay silent
        poll_stream(200, 1'b0);
        expect_lossless();

        set_enable(4'b1111);
        poll_stream(1500, 1'b0);
        expect_lossless();

        // Dense pulses with no reads until the stream ends
        gap_words = 2;
        for (int ch = 0; ch < NUM_CH; ch++) begin
            burst_base[ch] = m_cnt[ch];
        end
        @(posedge CLK40);
        gen_cycles = 150;
        wait (gen_cycles == 0);
        gap_words = 40;
        drain_fifo(1'b1);
        for (int ch = 0; ch < NUM_CH; ch++) begin
            assert (m_cnt[ch] - burst_base[ch] > 16) else begin
                $display("burst gave only %0d events on channel %0d",
                         m_cnt[ch] - burst_base[ch], ch);
                stop_with_failure();
            end
            skipped[ch] = skipped[ch] + m_cnt[ch] - rd_next[ch];  // Lost after last read
            rd_next[ch] = m_cnt[ch];
            read_reg(ADDR_LOST + 8'(4 * ch), rdata, err);
            expect_value($sformatf("lost_cnt ch%0d", ch), rdata,
                         32'((skipped[ch] > 255) ? 255 : skipped[ch]));
        end

        // Refill the FIFO so the soft clear has entries and lost hits to drop
        gap_words = 2;
        @(posedge CLK40);
        gen_cycles = 100;
        wait (gen_cycles == 0);
        gap_words = 40;
        repeat (8) @(negedge CLK40);  // Last pulses reach the FIFO
        read_reg(ADDR_STATUS, rdata, err);
        expect_value("status", rdata, 32'(FIFO_DEPTH) << 4);  // Level 16 and not empty

        write_reg(ADDR_CTRL, 32'h1, err);
        clear_model();
        read_reg(ADDR_STATUS, rdata, err);
        expect_value("status", rdata, 32'h1);
        read_reg(ADDR_ENABLE, rdata, err);
        expect_value("enable", rdata, 32'hf);
        expect_lossless();
        poll_stream(300, 1'b0);  // Event numbers restart at 0
        for (int ch = 0; ch < NUM_CH; ch++) begin
            assert (rd_next[ch] > 0) else begin
                $display("no hits read from channel %0d after the soft clear", ch);
                stop_with_failure();
            end
        end
        expect_lossless();

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* sources.f */
src/tdc_pkg.sv
src/tdc_csr.sv
src/tdc_channel.sv
src/hit_merger.sv
src/hit_fifo.sv
src/tdc_array_top.sv
verif/tdc_array_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the TDC array testbench with Verilator, runs it and checks sim.log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tdc_array_tb \
    -f sources.f -o Vtdc_array_tb

status=0
./obj_dir/Vtdc_array_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Result: FAILED" sim.log; then
    exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
    echo "simulation ended without a result (exit status $status)"
    exit 1
fi
exit 0
